// ==== hdl/hub_pkg.sv ====
package hub_pkg;

  //////////////////////////////
  // bus geometry
  localparam int DATA_W     = 32;
  localparam int BE_W       = 4;    // one we_n bit per byte lane
  localparam int EBI_ADDR_W = 24;   // word address, A31..A8 on the host side
  localparam int IDX_W      = 6;    // low address bits used as register index

  localparam int N_GPIO = 3;

  //////////////////////////////
  // register map
  localparam logic [IDX_W-1:0] GPIO_OUT_BASE = 6'd0;   // banks 0..2
  localparam logic [IDX_W-1:0] GPIO_IN_BASE  = 6'd4;   // banks 4..6
  localparam logic [IDX_W-1:0] UART_CR       = 6'd16;
  localparam logic [IDX_W-1:0] UART_TTR      = 6'd17;
  localparam logic [IDX_W-1:0] UART_SR       = 6'd18;
  localparam logic [IDX_W-1:0] UART_TDR      = 6'd19;
  localparam logic [IDX_W-1:0] ID_REG        = 6'd31;
  // out-of-range addresses land here, nothing decodes it
  localparam logic [IDX_W-1:0] IDX_NONE      = '1;

  //////////////////////////////
  // uart bit positions
  localparam int CR_TX_EN = 0;   // transmit enable
  localparam int CR_TX_IE = 1;   // interrupt enable
  localparam int SR_BUSY  = 0;   // frame on the line
  localparam int SR_OVR   = 1;   // sticky, cleared by SR read

  localparam int TTR_W = 16;     // clocks per bit
  localparam logic [TTR_W-1:0] TTR_RESET = 16'd16;
  localparam logic [TTR_W-1:0] TTR_MIN   = 16'd2;

  localparam logic [DATA_W-1:0] HUB_ID = 32'h4542_0001;

endpackage

// ==== hdl/ebi_decode.sv ====
`timescale 1ns/100ps

module ebi_decode (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            cs_n_i,
  input  logic                            oe_n_i,
  input  logic [hub_pkg::BE_W-1:0]        we_n_i,
  input  logic [hub_pkg::EBI_ADDR_W-1:0]  ebi_addr_i,
  input  logic [hub_pkg::DATA_W-1:0]      ebi_data_i,
  output logic [hub_pkg::BE_W-1:0]        wr_be_o,
  output logic                            rd_stb_o,
  output logic                            rd_active_o,
  output logic [hub_pkg::IDX_W-1:0]       reg_idx_o,
  output logic [hub_pkg::DATA_W-1:0]      wr_data_o
);

  logic                           cs_n_q;
  logic                           oe_n_q;
  logic [hub_pkg::BE_W-1:0]       we_n_q;
  logic [hub_pkg::EBI_ADDR_W-1:0] addr_q;
  logic [hub_pkg::DATA_W-1:0]     data_q;
  logic                           wr_cond, rd_cond;
  logic                           wr_cond_d, rd_cond_d;
  logic                           in_range;

  //////////////////////////////
  // pin sampling
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cs_n_q <= 1'b1;
      oe_n_q <= 1'b1;
      we_n_q <= '1;
    end else begin
      cs_n_q <= cs_n_i;
      oe_n_q <= oe_n_i;
      we_n_q <= we_n_i;
    end
    addr_q <= ebi_addr_i;
    data_q <= ebi_data_i;
  end

  assign wr_cond     = !cs_n_q && (we_n_q != '1);
  assign rd_cond     = !cs_n_q && !oe_n_q;
  assign rd_active_o = rd_cond;
  // upper address bits must be clear for a hit
  assign in_range    = (addr_q[hub_pkg::EBI_ADDR_W-1:hub_pkg::IDX_W] == '0);

  //////////////////////////////
  // access start detection
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_cond_d <= 1'b0;
      rd_cond_d <= 1'b0;
      wr_be_o   <= '0;
      rd_stb_o  <= 1'b0;
    end else begin
      wr_cond_d <= wr_cond;
      rd_cond_d <= rd_cond;
      wr_be_o   <= (wr_cond && !wr_cond_d) ? ~we_n_q : '0;  // one cycle per access
      rd_stb_o  <= rd_cond && !rd_cond_d;
    end
    if ((wr_cond && !wr_cond_d) || (rd_cond && !rd_cond_d)) begin
      reg_idx_o <= in_range ? addr_q[hub_pkg::IDX_W-1:0] : hub_pkg::IDX_NONE;
      wr_data_o <= data_q;
    end
  end

  // host must not assert we_n and oe_n together
  wr_rd_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !((wr_be_o != '0) && rd_stb_o));

endmodule

// ==== hdl/gpio_bank.sv ====
`timescale 1ns/100ps

module gpio_bank (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic [hub_pkg::BE_W-1:0]                          wr_be_i,
  input  logic [hub_pkg::IDX_W-1:0]                         reg_idx_i,
  input  logic [hub_pkg::DATA_W-1:0]                        wr_data_i,
  input  logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]   gpio_in_i,
  output logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]   gpio_out_o,
  output logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]   gpio_in_sync_o
);

  logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0] in_meta_q;  // first sync stage

  //////////////////////////////
  // output banks
  // byte-lane update, input indices are never decoded here
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_out_o <= '0;
    end else begin
      for (int b = 0; b < hub_pkg::N_GPIO; b++) begin
        if (int'(reg_idx_i) == int'(hub_pkg::GPIO_OUT_BASE) + b) begin
          for (int k = 0; k < hub_pkg::BE_W; k++) begin
            if (wr_be_i[k]) begin
              gpio_out_o[b][8*k +: 8] <= wr_data_i[8*k +: 8];
            end
          end
        end
      end
    end
  end

  //////////////////////////////
  // input synchronizers
  always_ff @(posedge clk_i) begin
    in_meta_q      <= gpio_in_i;
    gpio_in_sync_o <= in_meta_q;
  end

endmodule

// ==== hdl/uart_tx_channel.sv ====
`timescale 1ns/100ps

module uart_tx_channel (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [hub_pkg::BE_W-1:0]     wr_be_i,
  input  logic                         rd_stb_i,
  input  logic [hub_pkg::IDX_W-1:0]    reg_idx_i,
  input  logic [hub_pkg::DATA_W-1:0]   wr_data_i,
  output logic [hub_pkg::DATA_W-1:0]   cr_o,
  output logic [hub_pkg::DATA_W-1:0]   ttr_o,
  output logic [hub_pkg::DATA_W-1:0]   sr_o,
  output logic                         uart_tx_o,
  output logic                         uart_int_o
);

  logic [1:0]                  cr_q;       // tx_en, tx_ie
  logic [hub_pkg::TTR_W-1:0]   ttr_q;
  logic [hub_pkg::TTR_W-1:0]   ttr_eff;
  logic [hub_pkg::TTR_W-1:0]   tick_q;     // clocks into current bit
  logic [3:0]                  bit_q;      // bits sent in this frame
  logic [9:0]                  shift_q;    // stop, data, start
  logic                        busy_q;
  logic                        ovr_q;
  logic                        cr_wr, ttr_wr, tdr_wr, sr_rd;
  logic                        tick_done;

  assign cr_wr  = (reg_idx_i == hub_pkg::UART_CR) && wr_be_i[0];
  assign ttr_wr = (reg_idx_i == hub_pkg::UART_TTR);
  assign tdr_wr = (reg_idx_i == hub_pkg::UART_TDR) && (wr_be_i != '0);
  assign sr_rd  = rd_stb_i && (reg_idx_i == hub_pkg::UART_SR);

  assign ttr_eff   = (ttr_q < hub_pkg::TTR_MIN) ? hub_pkg::TTR_MIN : ttr_q;
  assign tick_done = (tick_q == ttr_eff - 1'b1);

  //////////////////////////////
  // control and bit-time registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cr_q  <= '0;
      ttr_q <= hub_pkg::TTR_RESET;
    end else begin
      if (cr_wr) cr_q <= wr_data_i[1:0];
      if (ttr_wr) begin
        for (int k = 0; k < hub_pkg::TTR_W / 8; k++) begin
          if (wr_be_i[k]) ttr_q[8*k +: 8] <= wr_data_i[8*k +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // transmitter
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      ovr_q   <= 1'b0;
      tick_q  <= '0;
      bit_q   <= '0;
      shift_q <= '1;  // line idles high
    end else begin
      if (sr_rd) ovr_q <= 1'b0;
      if (tdr_wr && busy_q) ovr_q <= 1'b1;  // byte dropped
      if (!busy_q) begin
        if (tdr_wr && cr_q[hub_pkg::CR_TX_EN]) begin
          busy_q  <= 1'b1;
          shift_q <= {1'b1, wr_data_i[7:0], 1'b0};
          tick_q  <= '0;
          bit_q   <= '0;
        end
      end else if (tick_done) begin
        tick_q  <= '0;
        shift_q <= {1'b1, shift_q[9:1]};  // lsb first, refill with idle
        bit_q   <= bit_q + 4'd1;
        if (bit_q == 4'd9) busy_q <= 1'b0;  // stop bit done
      end else begin
        tick_q <= tick_q + 1'b1;
      end
    end
  end

  assign uart_tx_o  = shift_q[0];
  assign uart_int_o = cr_q[hub_pkg::CR_TX_IE] && !busy_q;  // ready for next byte

  always_comb begin
    cr_o  = '0;
    ttr_o = '0;
    sr_o  = '0;
    cr_o[hub_pkg::CR_TX_EN]    = cr_q[hub_pkg::CR_TX_EN];
    cr_o[hub_pkg::CR_TX_IE]    = cr_q[hub_pkg::CR_TX_IE];
    ttr_o[hub_pkg::TTR_W-1:0]  = ttr_q;
    sr_o[hub_pkg::SR_BUSY]     = busy_q;
    sr_o[hub_pkg::SR_OVR]      = ovr_q;
  end

  tx_idle_high_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy_q |-> uart_tx_o);

  bit_cnt_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bit_q <= 4'd10);

endmodule

// ==== hdl/read_mux.sv ====
`timescale 1ns/100ps

module read_mux (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic                                             rd_stb_i,
  input  logic                                             rd_active_i,
  input  logic [hub_pkg::IDX_W-1:0]                        reg_idx_i,
  input  logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]  gpio_out_i,
  input  logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]  gpio_in_i,
  input  logic [hub_pkg::DATA_W-1:0]                       cr_i,
  input  logic [hub_pkg::DATA_W-1:0]                       ttr_i,
  input  logic [hub_pkg::DATA_W-1:0]                       sr_i,
  output logic [hub_pkg::DATA_W-1:0]                       ebi_data_o,
  output logic                                             ebi_data_oe_o
);

  logic [hub_pkg::DATA_W-1:0] rd_word;

  // tdr, unmapped and out-of-range indices fall through to zero
  always_comb begin
    rd_word = '0;
    for (int b = 0; b < hub_pkg::N_GPIO; b++) begin
      if (int'(reg_idx_i) == int'(hub_pkg::GPIO_OUT_BASE) + b) rd_word = gpio_out_i[b];
      if (int'(reg_idx_i) == int'(hub_pkg::GPIO_IN_BASE) + b) rd_word = gpio_in_i[b];
    end
    case (reg_idx_i)
      hub_pkg::UART_CR:  rd_word = cr_i;
      hub_pkg::UART_TTR: rd_word = ttr_i;
      hub_pkg::UART_SR:  rd_word = sr_i;
      hub_pkg::ID_REG:   rd_word = hub_pkg::HUB_ID;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_stb_i) ebi_data_o <= rd_word;  // held until next read
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) ebi_data_oe_o <= 1'b0;
    else          ebi_data_oe_o <= rd_active_i;
  end

endmodule

// ==== hdl/ebi_periph_top.sv ====
`timescale 1ns/100ps

module ebi_periph_top (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic                                             cs_n_i,
  input  logic                                             oe_n_i,
  input  logic [hub_pkg::BE_W-1:0]                         we_n_i,
  input  logic [hub_pkg::EBI_ADDR_W-1:0]                   ebi_addr_i,
  input  logic [hub_pkg::DATA_W-1:0]                       ebi_data_i,
  input  logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]  gpio_in_i,
  output logic [hub_pkg::DATA_W-1:0]                       ebi_data_o,
  output logic                                             ebi_data_oe_o,
  output logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]  gpio_out_o,
  output logic                                             uart_tx_o,
  output logic                                             uart_int_o
);

  logic [hub_pkg::BE_W-1:0]                         wr_be;
  logic                                             rd_stb, rd_active;
  logic [hub_pkg::IDX_W-1:0]                        reg_idx;
  logic [hub_pkg::DATA_W-1:0]                       wr_data;
  logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0]  gpio_in_sync;
  logic [hub_pkg::DATA_W-1:0]                       cr, ttr, sr;

  //////////////////////////////
  // bus front end
  ebi_decode u_decode (
    .clk_i, .rst_n_i, .cs_n_i, .oe_n_i, .we_n_i, .ebi_addr_i, .ebi_data_i,
    .wr_be_o     (wr_be),
    .rd_stb_o    (rd_stb),
    .rd_active_o (rd_active),
    .reg_idx_o   (reg_idx),
    .wr_data_o   (wr_data)
  );

  //////////////////////////////
  // peripherals
  gpio_bank u_gpio (
    .clk_i, .rst_n_i, .gpio_in_i, .gpio_out_o,
    .wr_be_i        (wr_be),
    .reg_idx_i      (reg_idx),
    .wr_data_i      (wr_data),
    .gpio_in_sync_o (gpio_in_sync)
  );

  uart_tx_channel u_uart (
    .clk_i, .rst_n_i, .uart_tx_o, .uart_int_o,
    .wr_be_i   (wr_be),
    .rd_stb_i  (rd_stb),
    .reg_idx_i (reg_idx),
    .wr_data_i (wr_data),
    .cr_o      (cr),
    .ttr_o     (ttr),
    .sr_o      (sr)
  );

  read_mux u_rdmux (
    .clk_i, .rst_n_i, .ebi_data_o, .ebi_data_oe_o,
    .rd_stb_i    (rd_stb),
    .rd_active_i (rd_active),
    .reg_idx_i   (reg_idx),
    .gpio_out_i  (gpio_out_o),
    .gpio_in_i   (gpio_in_sync),
    .cr_i        (cr),
    .ttr_i       (ttr),
    .sr_i        (sr)
  );

endmodule

// ==== dv/tb_ebi_periph.sv ====
`timescale 1ns/100ps

module tb_ebi_periph;

  localparam int CLK_PERIOD  = 8;
  localparam int BUS_CYCLES  = 1500;      // rough length of all bus traffic
  localparam int N_FRAMES    = 5;
  localparam int FRAME_MAX   = 10 * 32;   // frame cycles at the largest ttr
  localparam int WATCHDOG_NS = 2 * (BUS_CYCLES + N_FRAMES * FRAME_MAX) * CLK_PERIOD;

  logic                                            clk, rst_n, cs_n, oe_n;
  logic [hub_pkg::BE_W-1:0]                        we_n;
  logic [hub_pkg::EBI_ADDR_W-1:0]                  addr;
  logic [hub_pkg::DATA_W-1:0]                      wdata, rdata;
  logic [hub_pkg::N_GPIO-1:0][hub_pkg::DATA_W-1:0] gpio_in, gpio_out;
  logic                                            data_oe, uart_tx, uart_int;

  // register map model
  logic [31:0] gpio_out_m [hub_pkg::N_GPIO];
  logic [31:0] gpio_in_m  [hub_pkg::N_GPIO];
  logic [1:0]  cr_m;
  logic [15:0] ttr_m;
  logic        busy_m, ovr_m;
  logic [31:0] rng_state;

  string       cmp_name_q [$];
  logic [31:0] cmp_exp_q  [$];
  logic [31:0] cmp_act_q  [$];
  logic [7:0]  rx_q       [$];   // bytes seen on the uart line

  ebi_periph_top dut_i (
    .clk_i (clk), .rst_n_i (rst_n), .cs_n_i (cs_n), .oe_n_i (oe_n), .we_n_i (we_n),
    .ebi_addr_i (addr), .ebi_data_i (wdata), .gpio_in_i (gpio_in),
    .ebi_data_o (rdata), .ebi_data_oe_o (data_oe), .gpio_out_o (gpio_out),
    .uart_tx_o (uart_tx), .uart_int_o (uart_int)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // helpers
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // expected read word at a bus address
  function automatic logic [31:0] expected_word(input logic [23:0] a);
    int          idx;
    logic [31:0] word;
    idx  = int'(a[5:0]);
    word = '0;
    if (a[23:6] == '0) begin
      if (idx < hub_pkg::N_GPIO) word = gpio_out_m[idx];
      else if (idx >= 4 && idx < 4 + hub_pkg::N_GPIO) word = gpio_in_m[idx - 4];
      else if (idx == int'(hub_pkg::UART_CR)) word = {30'd0, cr_m};
      else if (idx == int'(hub_pkg::UART_TTR)) word = {16'd0, ttr_m};
      else if (idx == int'(hub_pkg::UART_SR)) word = {30'd0, ovr_m, busy_m};
      else if (idx == int'(hub_pkg::ID_REG)) word = 32'h4542_0001;
    end
    return word;
  endfunction

  task automatic model_write(input logic [23:0] a, input logic [31:0] d, input logic [3:0] be);
    int idx;
    idx = int'(a[5:0]);
    if (a[23:6] == '0) begin
      for (int k = 0; k < 4; k++) begin
        if (be[k] && idx < hub_pkg::N_GPIO) gpio_out_m[idx][8*k +: 8] = d[8*k +: 8];
        if (be[k] && k < 2 && idx == int'(hub_pkg::UART_TTR)) ttr_m[8*k +: 8] = d[8*k +: 8];
      end
      if (be[0] && idx == int'(hub_pkg::UART_CR)) cr_m = d[1:0];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////
  // bus access tasks
  task automatic bus_write(input logic [23:0] a, input logic [31:0] d, input logic [3:0] be);
    @(posedge clk);
    #1;
    cs_n  = 1'b0;
    we_n  = ~be;
    addr  = a;
    wdata = d;
    repeat (3) @(posedge clk);
    #1;
    cs_n = 1'b1;
    we_n = '1;
    model_write(a, d, be);
  endtask

  task automatic bus_read(input string name, input logic [23:0] a);
    @(posedge clk);
    #1;
    cs_n = 1'b0;
    oe_n = 1'b0;
    addr = a;
    repeat (4) @(posedge clk);
    #1;
    cmp_name_q.push_back(name);
    cmp_exp_q.push_back(expected_word(a));
    cmp_act_q.push_back(rdata);
    cmp_name_q.push_back({name, " oe"});
    cmp_exp_q.push_back(32'd1);
    cmp_act_q.push_back({31'd0, data_oe});
    if (a == 24'(hub_pkg::UART_SR)) ovr_m = 1'b0;  // status read clears overrun
    cs_n = 1'b1;
    oe_n = 1'b1;
  endtask

  always @(negedge clk) begin : comparator
    string       n;
    logic [31:0] e, a;
    while (cmp_exp_q.size() != 0) begin
      n = cmp_name_q.pop_front();
      e = cmp_exp_q.pop_front();
      a = cmp_act_q.pop_front();
      check_value(n, e, a);
    end
  end

  //////////////////////////////
  // uart line sampler, mid-bit
  initial begin : uart_sampler
    logic [7:0] rx_byte;
    @(posedge rst_n);
    forever begin
      @(negedge uart_tx);
      repeat (int'(ttr_m) / 2) @(negedge clk);
      check_value("uart start bit", 32'd0, {31'd0, uart_tx});
      for (int i = 0; i < 8; i++) begin
        repeat (int'(ttr_m)) @(negedge clk);
        rx_byte[i] = uart_tx;
      end
      repeat (int'(ttr_m)) @(negedge clk);
      check_value("uart stop bit", 32'd1, {31'd0, uart_tx});
      rx_q.push_back(rx_byte);
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, a bus access or uart frame never finished", WATCHDOG_NS);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  task automatic wait_frame(input string name, input logic [7:0] exp_byte);
    while (rx_q.size() == 0) @(posedge clk);
    check_value(name, {24'd0, exp_byte}, {24'd0, rx_q.pop_front()});
    repeat (int'(ttr_m)) @(posedge clk);  // past the stop bit
    #1;
    busy_m = 1'b0;
  endtask

  //////////////////////////////
  // test sequence
  initial begin : main
    logic [31:0] r;
    logic [7:0]  byte1;
    cs_n = 1'b1;
    oe_n = 1'b1;
    we_n = '1;
    addr = '0;
    wdata = '0;
    gpio_in = '0;
    rst_n = 1'b0;
    for (int b = 0; b < hub_pkg::N_GPIO; b++) begin
      gpio_out_m[b] = '0;
      gpio_in_m[b]  = '0;
    end
    cr_m = '0;
    ttr_m = 16'd16;
    busy_m = 1'b0;
    ovr_m = 1'b0;
    rng_state = 32'he203_e985;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_value("reset uart_tx", 32'd1, {31'd0, uart_tx});
    check_value("reset uart_int", 32'd0, {31'd0, uart_int});
    check_value("reset data oe", 32'd0, {31'd0, data_oe});
    check_value("reset gpio_out", 32'd0, gpio_out[0] | gpio_out[1] | gpio_out[2]);
    bus_read("reset cr", 24'(hub_pkg::UART_CR));
    bus_read("reset ttr", 24'(hub_pkg::UART_TTR));

    for (int n = 0; n < 8; n++) begin
      for (int b = 0; b < hub_pkg::N_GPIO; b++) begin
        r = next_rand();
        bus_write(24'(b), next_rand(), r[3:0]);
        check_value("gpio out pins", gpio_out_m[b], gpio_out[b]);
        bus_read("gpio out readback", 24'(b));
      end
    end

    for (int n = 0; n < 4; n++) begin
      @(posedge clk);
      #1;
      for (int b = 0; b < hub_pkg::N_GPIO; b++) begin
        gpio_in_m[b] = next_rand();
        gpio_in[b]   = gpio_in_m[b];
      end
      repeat (3) @(posedge clk);
      for (int b = 0; b < hub_pkg::N_GPIO; b++) bus_read("gpio in readback", 24'(4 + b));
    end

    // single frame
    r = next_rand();
    bus_write(24'(hub_pkg::UART_TTR), 32'd8 + (r % 32'd24), 4'b0011);
    bus_read("ttr readback", 24'(hub_pkg::UART_TTR));
    bus_write(24'(hub_pkg::UART_CR), 32'h3, 4'hf);
    check_value("uart int idle", 32'd1, {31'd0, uart_int});
    r = next_rand();
    byte1 = r[7:0];
    bus_write(24'(hub_pkg::UART_TDR), {24'd0, byte1}, 4'h1);
    busy_m = 1'b1;
    check_value("uart int busy", 32'd0, {31'd0, uart_int});
    bus_read("sr busy", 24'(hub_pkg::UART_SR));
    wait_frame("uart frame", byte1);
    check_value("uart int after frame", 32'd1, {31'd0, uart_int});
    bus_read("sr idle", 24'(hub_pkg::UART_SR));

    // overrun, then a write with the transmitter disabled
    r = next_rand();
    byte1 = r[7:0];
    bus_write(24'(hub_pkg::UART_TDR), {24'd0, byte1}, 4'h1);
    busy_m = 1'b1;
    bus_write(24'(hub_pkg::UART_TDR), next_rand(), 4'h1);
    ovr_m = 1'b1;
    bus_read("sr overrun set", 24'(hub_pkg::UART_SR));
    bus_read("sr overrun cleared", 24'(hub_pkg::UART_SR));
    wait_frame("uart frame after overrun", byte1);
    repeat (12 * int'(ttr_m)) @(posedge clk);
    check_value("no frame for dropped byte", 32'd0, 32'(rx_q.size()));
    bus_write(24'(hub_pkg::UART_CR), 32'h2, 4'hf);
    bus_write(24'(hub_pkg::UART_TDR), next_rand(), 4'h1);
    repeat (12 * int'(ttr_m)) @(posedge clk);
    check_value("no frame when disabled", 32'd0, 32'(rx_q.size()));
    bus_read("sr disabled", 24'(hub_pkg::UART_SR));

    bus_read("id word", 24'(hub_pkg::ID_REG));
    bus_read("unmapped index", 24'd8);
    bus_read("tdr reads zero", 24'(hub_pkg::UART_TDR));
    bus_read("upper address bits", 24'h010011);

    repeat (2) @(posedge clk);
    if (cmp_exp_q.size() == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Comparator still holds %0d results at the end", cmp_exp_q.size());
      $display("Checks failed");
      $fatal(1, "results left unchecked");
    end
  end

endmodule

// ==== vlog.f ====
hdl/hub_pkg.sv
hdl/ebi_decode.sv
hdl/gpio_bank.sv
hdl/uart_tx_channel.sv
hdl/read_mux.sv
hdl/ebi_periph_top.sv
dv/tb_ebi_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, decide on the log
set -e

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  -f vlog.f --top-module tb_ebi_periph -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

grep -q "All checks passed" sim.log
echo "simulation passed"
